//--- list.f
rtl/mem_if_pkg.sv
rtl/pipeline_pkg.sv
rtl/ex_mem_reg.sv
rtl/dcache_req_gen.sv
rtl/data_sram.sv
rtl/mem_stage.sv
rtl/mem_wb_reg.sv
rtl/mem_subsystem.sv
verification/mem_subsystem_props.sv
verification/mem_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= mem_subsystem_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "exit status 0" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/mem_subsystem_tb.sv
module mem_subsystem_tb
    import pipeline_pkg::*;
    import mem_if_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ISSUE_WIDTH  = 2;
    localparam int RESP_LATENCY = 2;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = RESP_LATENCY + 8;
    // 12 + 9 + 7 + 9 + 6 + 1 operations over all tests
    localparam int NUM_OPS      = 44;
    localparam int WATCHDOG_NS  = (NUM_OPS * (RESP_LATENCY + 4) + 3 * RESET_CYCLES + 50) * 20;

    logic                        clk;
    logic                        arst_n_i;
    ex_mem_t [ISSUE_WIDTH - 1:0] ex_i;
    mem_wb_t [ISSUE_WIDTH - 1:0] wb_o;
    fwd_t    [ISSUE_WIDTH - 1:0] fwd_o;
    logic                        pause_o;

    // byte-level memory model, 256 words
    logic [7:0]                  ref_mem [1024];
    int                          errors;
    int                          seed;
    addr_t                       pc_cnt;
    mem_wb_t [ISSUE_WIDTH - 1:0] last_wb;
    fwd_t    [ISSUE_WIDTH - 1:0] last_fwd;
    int                          last_pause;

    mem_subsystem u_dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ex_i     (ex_i),
        .wb_o     (wb_o),
        .fwd_o    (fwd_o),
        .pause_o  (pause_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic ex_mem_t make_op(aluop_t op, addr_t a, bus32_t d, reg_addr_t rd);
        ex_mem_t e;
        pc_cnt += 4;
        e.inst_valid     = 1'b1;
        e.pc             = pc_cnt;
        e.aluop          = op;
        e.mem_addr       = a;
        e.reg_write_en   = !(op inside {STB, STH, STW, SCW});
        e.reg_write_addr = rd;
        e.reg_write_data = d;
        return e;
    endfunction

    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
    endtask

    // drive one bundle, wait out the pause, then collect wb_o after a bubble
    task automatic run_op(input string name, input ex_mem_t op0, input ex_mem_t op1);
        int waited;
        ex_i[0] = op0;
        ex_i[1] = op1;
        @(posedge clk);
        #2;
        waited = 0;
        while (pause_o && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
            #2;
        end
        if (pause_o) begin
            errors++;
            $display("%s: pause_o still high after %0d cycles", name, WAIT_LIMIT);
        end
        last_pause = waited;
        last_fwd   = fwd_o;
        ex_i       = '0;
        @(posedge clk);
        #2;
        last_wb = wb_o;
    endtask

    task automatic store_ref(input aluop_t op, input addr_t a, input bus32_t d);
        logic [9:0] i;
        i = a[9:0];
        case (op)
            STB: ref_mem[i] = d[7:0];
            STH: begin
                ref_mem[{i[9:1], 1'b0}] = d[7:0];
                ref_mem[{i[9:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[{i[9:2], 2'(k)}] = d[8 * k +: 8];
                end
            end
        endcase
    endtask

    function automatic bus32_t load_expect(aluop_t op, addr_t a);
        logic [9:0]  i;
        logic [7:0]  b;
        logic [15:0] h;
        bus32_t      w;
        i = a[9:0];
        b = ref_mem[i];
        h = {ref_mem[{i[9:1], 1'b1}], ref_mem[{i[9:1], 1'b0}]};
        w = {ref_mem[{i[9:2], 2'd3}], ref_mem[{i[9:2], 2'd2}],
             ref_mem[{i[9:2], 2'd1}], ref_mem[{i[9:2], 2'd0}]};
        case (op)
            LDB:  return {{24{b[7]}}, b};
            LDBU: return {24'h0, b};
            LDH:  return i[0] ? 32'h0 : {{16{h[15]}}, h};
            LDHU: return i[0] ? 32'h0 : {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic do_store(input string name, input aluop_t op, input addr_t a, input bus32_t d);
        run_op(name, make_op(op, a, d, 5'd0), '0);
        store_ref(op, a, d);
        check({name, "_pause"}, RESP_LATENCY, last_pause);
        check({name, "_we"}, 0, 32'(last_wb[0].reg_write_en));
    endtask

    task automatic do_load(input string name, input aluop_t op, input addr_t a);
        run_op(name, make_op(op, a, '0, 5'd4), '0);
        check({name, "_pause"}, RESP_LATENCY, last_pause);
        check({name, "_valid"}, 1, 32'(last_wb[0].inst_valid));
        check(name, load_expect(op, a), last_wb[0].reg_write_data);
    endtask

    task automatic check_idle(input string name);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            check({name, "_valid"}, 0, 32'(wb_o[i].inst_valid));
            check({name, "_we"}, 0, 32'(wb_o[i].reg_write_en));
        end
        check({name, "_pause"}, 0, 32'(pause_o));
    endtask

    task automatic test_word_round_trip();
        addr_t a [4];
        for (int n = 0; n < 4; n++) begin
            a[n] = {22'h0, 8'(n * 37 + 5), 2'b00};
            do_store("word_st_w", STW, a[n], $random(seed));
        end
        for (int n = 0; n < 4; n++) begin
            do_load("word_ld_w", LDW, a[n]);
            do_load("word_ll_w", LLW, a[n]);
        end
    endtask

    task automatic test_byte_loads();
        bus32_t d;
        // bytes 1 and 3 negative, the others random
        d = $random(seed) | 32'h8000_8000;
        do_store("byte_st_w", STW, 32'h0000_0100, d);
        for (int off = 0; off < 4; off++) begin
            do_load("byte_ld_b", LDB, 32'h0000_0100 + off);
            do_load("byte_ld_bu", LDBU, 32'h0000_0100 + off);
        end
    endtask

    task automatic test_half_loads();
        bus32_t d;
        d = ($random(seed) & 32'hffff_7fff) | 32'h8000_0000;
        do_store("half_st_w", STW, 32'h0000_0200, d);
        do_load("half_ld_h_0", LDH, 32'h0000_0200);
        do_load("half_ld_hu_0", LDHU, 32'h0000_0200);
        do_load("half_ld_h_2", LDH, 32'h0000_0202);
        do_load("half_ld_hu_2", LDHU, 32'h0000_0202);
        // misaligned halfword gives zero
        do_load("half_ld_h_1", LDH, 32'h0000_0201);
        do_load("half_ld_hu_1", LDHU, 32'h0000_0201);
    endtask

    task automatic test_partial_stores();
        do_store("part_st_w", STW, 32'h0000_0300, $random(seed));
        for (int off = 0; off < 4; off++) begin
            do_store("part_st_b", STB, 32'h0000_0300 + off, $random(seed));
        end
        do_load("part_ld_w_b", LDW, 32'h0000_0300);
        do_store("part_st_h_0", STH, 32'h0000_0300, $random(seed));
        do_store("part_st_h_2", STH, 32'h0000_0302, $random(seed));
        do_load("part_ld_w_h", LDW, 32'h0000_0300);
    endtask

    task automatic test_pause_pass();
        ex_mem_t op0;
        ex_mem_t op1;
        bus32_t  exp0;
        for (int n = 0; n < 6; n++) begin
            op1 = make_op(ALU_OTHER, '0, $random(seed), 5'(n + 1));
            if (n < 4) begin
                op0 = make_op(ALU_OTHER, '0, $random(seed), 5'(n + 10));
            end else if (n == 4) begin
                op0 = make_op(STW, 32'h0000_0380, $random(seed), 5'd0);
            end else begin
                op0 = make_op(LDW, 32'h0000_0380, '0, 5'd3);
            end
            run_op("pass", op0, op1);
            if (op0.aluop == STW) begin
                store_ref(STW, op0.mem_addr, op0.reg_write_data);
            end
            // the load returns memory, everything else passes through
            exp0 = (n == 5) ? load_expect(LDW, op0.mem_addr) : op0.reg_write_data;
            check("pass_pause", (n < 4) ? 0 : RESP_LATENCY, last_pause);
            check("pass_fwd0_data", exp0, last_fwd[0].reg_write_data);
            check("pass_fwd0_addr", 32'(op0.reg_write_addr), 32'(last_fwd[0].reg_write_addr));
            check("pass_fwd0_en", 32'(op0.reg_write_en), 32'(last_fwd[0].reg_write_en));
            check("pass_fwd1_data", op1.reg_write_data, last_fwd[1].reg_write_data);
            check("pass_fwd1_addr", 32'(op1.reg_write_addr), 32'(last_fwd[1].reg_write_addr));
            check("pass_fwd1_en", 32'(op1.reg_write_en), 32'(last_fwd[1].reg_write_en));
            check("pass_wb0_valid", 1, 32'(last_wb[0].inst_valid));
            check("pass_wb0_pc", op0.pc, last_wb[0].pc);
            check("pass_wb0_addr", 32'(op0.reg_write_addr), 32'(last_wb[0].reg_write_addr));
            check("pass_wb0_en", 32'(op0.reg_write_en), 32'(last_wb[0].reg_write_en));
            check("pass_wb0_data", exp0, last_wb[0].reg_write_data);
            check("pass_wb1_valid", 1, 32'(last_wb[1].inst_valid));
            check("pass_wb1_pc", op1.pc, last_wb[1].pc);
            check("pass_wb1_addr", 32'(op1.reg_write_addr), 32'(last_wb[1].reg_write_addr));
            check("pass_wb1_en", 32'(op1.reg_write_en), 32'(last_wb[1].reg_write_en));
            check("pass_wb1_data", op1.reg_write_data, last_wb[1].reg_write_data);
        end
    endtask

    task automatic test_reset();
        ex_i[0] = make_op(ALU_OTHER, '0, $random(seed), 5'd7);
        ex_i[1] = make_op(ALU_OTHER, '0, $random(seed), 5'd8);
        repeat (2) @(posedge clk);
        #2;
        check("reset_wb_busy", 1, 32'(wb_o[0].inst_valid));
        apply_reset();
        check_idle("reset_midrun");
        ex_i = '0;
    endtask

    initial begin
        seed     = 32'h9e5b_0e3a;
        errors   = 0;
        pc_cnt   = 32'h1c00_0000;
        ex_i     = '0;
        arst_n_i = 1'b0;
        apply_reset();
        check_idle("reset_initial");
        test_word_round_trip();
        test_byte_loads();
        test_half_loads();
        test_partial_stores();
        test_pause_pass();
        test_reset();
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verification/mem_subsystem_props.sv
module mem_subsystem_props
    import pipeline_pkg::*;
    import mem_if_pkg::*;
#(
    parameter int ISSUE_WIDTH  = 2,
    parameter int RESP_LATENCY = 2
) (
    input logic                        clk,
    input logic                        arst_n_i,
    input ex_mem_t [ISSUE_WIDTH - 1:0] ex_i,
    input ex_mem_t [ISSUE_WIDTH - 1:0] ex_q_i,
    input mem_wb_t [ISSUE_WIDTH - 1:0] res_i,
    input dcache_req_t                 req_i,
    input dcache_rsp_t                 rsp_i,
    input logic                        pause_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // pause only with a lane-0 load or store in the stage
    a_pause_mem: assert property (@(posedge clk) disable iff (!arst_n_i)
        pause_i |-> (ex_q_i[0].inst_valid && ex_q_i[0].aluop != ALU_OTHER))
        else $error("pause_o high without a lane-0 memory operation");

    a_rsp_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i.req |-> ##RESP_LATENCY rsp_i.data_ok)
        else $error("data_ok missing RESP_LATENCY cycles after req");

    a_rsp_only_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_i.data_ok |-> $past(req_i.req, RESP_LATENCY))
        else $error("data_ok without a req RESP_LATENCY cycles earlier");

    // lane 1 carries the word it captured from execute
    a_lane1_pass: assert property (@(posedge clk) disable iff (!arst_n_i)
        ($past(arst_n_i) && !$past(pause_i))
            |-> res_i[1].reg_write_data == $past(ex_i[1].reg_write_data))
        else $error("lane 1 result differs from its input");

endmodule

// checker on the stage and its RAM port
bind mem_subsystem mem_subsystem_props #(
    .ISSUE_WIDTH  (ISSUE_WIDTH),
    .RESP_LATENCY (RESP_LATENCY)
) u_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .ex_i     (ex_i),
    .ex_q_i   (ex_q),
    .res_i    (res),
    .req_i    (dreq),
    .rsp_i    (drsp),
    .pause_i  (pause_o)
);

//--- rtl/mem_subsystem.sv
module mem_subsystem
    import pipeline_pkg::*;
    import mem_if_pkg::*;
#(
    parameter int ISSUE_WIDTH  = 2,
    parameter int ADDR_BITS    = 8,
    parameter int RESP_LATENCY = 2
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  ex_mem_t [ISSUE_WIDTH - 1:0] ex_i,
    output mem_wb_t [ISSUE_WIDTH - 1:0] wb_o,
    output fwd_t    [ISSUE_WIDTH - 1:0] fwd_o,
    output logic                        pause_o
);

    ex_mem_t [ISSUE_WIDTH - 1:0] ex_q;
    mem_wb_t [ISSUE_WIDTH - 1:0] res;
    dcache_req_t                 dreq;
    dcache_rsp_t                 drsp;

    ex_mem_reg #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_ex_mem_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .pause_i  (pause_o),
        .ex_i     (ex_i),
        .ex_q_o   (ex_q)
    );

    dcache_req_gen u_dcache_req_gen (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_i     (ex_q[0]),
        .rsp_i    (drsp),
        .req_o    (dreq)
    );

    data_sram #(
        .ADDR_BITS    (ADDR_BITS),
        .RESP_LATENCY (RESP_LATENCY)
    ) u_data_sram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (dreq),
        .rsp_o    (drsp)
    );

    mem_stage #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_mem_stage (
        .ex_q_i  (ex_q),
        .rsp_i   (drsp),
        .res_o   (res),
        .fwd_o   (fwd_o),
        .pause_o (pause_o)
    );

    mem_wb_reg #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_mem_wb_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .pause_i  (pause_o),
        .res_i    (res),
        .wb_o     (wb_o)
    );

endmodule

//--- rtl/mem_wb_reg.sv
module mem_wb_reg
    import pipeline_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        pause_i,

    // from stage
    input  mem_wb_t [ISSUE_WIDTH - 1:0] res_i,

    // to writeback
    output mem_wb_t [ISSUE_WIDTH - 1:0] wb_o
);

    mem_wb_t [ISSUE_WIDTH - 1:0] wb_q;

    assign wb_o = wb_q;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                wb_q[i] <= '0;
            end else if (pause_i) begin
                // bubble while the access is pending
                wb_q[i] <= '0;
            end else begin
                wb_q[i] <= res_i[i];
            end
        end
    end

endmodule

//--- rtl/mem_stage.sv
module mem_stage
    import pipeline_pkg::*;
    import mem_if_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    // from input register
    input  ex_mem_t [ISSUE_WIDTH - 1:0] ex_q_i,

    // with data RAM
    input  dcache_rsp_t                 rsp_i,

    // to writeback
    output mem_wb_t [ISSUE_WIDTH - 1:0] res_o,

    // to dispatch
    output fwd_t    [ISSUE_WIDTH - 1:0] fwd_o,

    output logic                        pause_o
);

    logic        ld_op;
    logic        st_op;
    bus32_t      byte_sh;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    bus32_t      lane0_data;

    assign ld_op = ex_q_i[0].inst_valid && is_load_op(ex_q_i[0].aluop);
    assign st_op = ex_q_i[0].inst_valid && is_store_op(ex_q_i[0].aluop);

    // byte and halfword picked by the low address bits
    assign byte_sh = rsp_i.rdata >> {ex_q_i[0].mem_addr[1:0], 3'b000};
    assign ld_byte = byte_sh[7:0];
    assign ld_half = ex_q_i[0].mem_addr[1] ? rsp_i.rdata[31:16] : rsp_i.rdata[15:0];

    always_comb begin
        lane0_data = ex_q_i[0].reg_write_data;
        if (ld_op) begin
            lane0_data = '0;
            if (rsp_i.data_ok) begin
                case (ex_q_i[0].aluop)
                    LDB: lane0_data = {{24{ld_byte[7]}}, ld_byte};
                    LDBU: lane0_data = {24'b0, ld_byte};
                    LDH: begin
                        // odd halfword stays zero
                        if (!ex_q_i[0].mem_addr[0]) begin
                            lane0_data = {{16{ld_half[15]}}, ld_half};
                        end
                    end
                    LDHU: begin
                        if (!ex_q_i[0].mem_addr[0]) begin
                            lane0_data = {16'b0, ld_half};
                        end
                    end
                    default: lane0_data = rsp_i.rdata;
                endcase
            end
        end
    end

    assign pause_o = (ld_op || st_op) && !rsp_i.data_ok;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        assign res_o[i].inst_valid     = ex_q_i[i].inst_valid;
        assign res_o[i].pc             = ex_q_i[i].pc;
        assign res_o[i].reg_write_en   = ex_q_i[i].reg_write_en;
        assign res_o[i].reg_write_addr = ex_q_i[i].reg_write_addr;

        if (i == 0) begin : g_mem_lane
            assign res_o[i].reg_write_data = lane0_data;
        end else begin : g_alu_lane
            assign res_o[i].reg_write_data = ex_q_i[i].reg_write_data;
        end

        assign fwd_o[i].reg_write_en   = res_o[i].reg_write_en;
        assign fwd_o[i].reg_write_addr = res_o[i].reg_write_addr;
        assign fwd_o[i].reg_write_data = res_o[i].reg_write_data;
    end

endmodule

//--- rtl/data_sram.sv
module data_sram
    import mem_if_pkg::*;
#(
    parameter int ADDR_BITS    = 8,
    parameter int RESP_LATENCY = 2
) (
    input  logic        clk,
    input  logic        arst_n_i,
    input  dcache_req_t req_i,
    output dcache_rsp_t rsp_o
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    bus32_t                  mem [DEPTH];
    logic [ADDR_BITS - 1:0]  word_idx;
    logic [RESP_LATENCY-1:0] vld_q;
    bus32_t                  data_q [RESP_LATENCY];

    assign word_idx = req_i.addr[ADDR_BITS + 1:2];

    // byte-masked write at the request edge
    always_ff @(posedge clk) begin
        if (req_i.req && req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.wstrb[b]) begin
                    mem[word_idx][8 * b +: 8] <= req_i.wdata[8 * b +: 8];
                end
            end
        end
    end

    // read word travels with the pending flag
    always_ff @(posedge clk) begin
        data_q[0] <= mem[word_idx];
        for (int k = 1; k < RESP_LATENCY; k++) begin
            data_q[k] <= data_q[k - 1];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= req_i.req;
            for (int k = 1; k < RESP_LATENCY; k++) begin
                vld_q[k] <= vld_q[k - 1];
            end
        end
    end

    assign rsp_o.data_ok = vld_q[RESP_LATENCY - 1];
    assign rsp_o.rdata   = data_q[RESP_LATENCY - 1];

endmodule

//--- rtl/dcache_req_gen.sv
module dcache_req_gen
    import pipeline_pkg::*;
    import mem_if_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,

    // lane 0 only
    input  ex_mem_t     op_i,
    input  dcache_rsp_t rsp_i,
    output dcache_req_t req_o
);

    logic       ld_op;
    logic       st_op;
    logic       outstanding_q;
    bus32_t     st_data;
    byte_mask_t st_mask;

    assign ld_op = op_i.inst_valid && is_load_op(op_i.aluop);
    assign st_op = op_i.inst_valid && is_store_op(op_i.aluop);

    // replicate store data into every lane of the word
    always_comb begin
        case (op_i.aluop)
            STB: begin
                st_data = {4{op_i.reg_write_data[7:0]}};
                st_mask = byte_mask_t'(4'b0001 << op_i.mem_addr[1:0]);
            end
            STH: begin
                st_data = {2{op_i.reg_write_data[15:0]}};
                st_mask = op_i.mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            STW, SCW: begin
                st_data = op_i.reg_write_data;
                st_mask = 4'b1111;
            end
            default: begin
                st_data = op_i.reg_write_data;
                st_mask = 4'b0000;
            end
        endcase
    end

    // one request per operation
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (rsp_i.data_ok) begin
            outstanding_q <= 1'b0;
        end else if (req_o.req) begin
            outstanding_q <= 1'b1;
        end
    end

    assign req_o.req   = (ld_op || st_op) && !outstanding_q;
    assign req_o.we    = st_op;
    assign req_o.addr  = {op_i.mem_addr[31:2], 2'b00};
    assign req_o.wdata = st_data;
    assign req_o.wstrb = st_op ? st_mask : 4'b0000;

endmodule

//--- rtl/ex_mem_reg.sv
module ex_mem_reg
    import pipeline_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          pause_i,

    // from execute
    input  ex_mem_t [ISSUE_WIDTH - 1:0]   ex_i,

    // to request generator and stage
    output ex_mem_t [ISSUE_WIDTH - 1:0]   ex_q_o
);

    ex_mem_t [ISSUE_WIDTH - 1:0] ex_q;

    assign ex_q_o = ex_q;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                ex_q[i] <= '0;
            end else if (!pause_i) begin
                ex_q[i] <= ex_i[i];
            end
            // hold while the access is pending
        end
    end

endmodule

//--- rtl/pipeline_pkg.sv
package pipeline_pkg;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

    // only the operations this stage tells apart
    typedef enum logic [3:0] {
        ALU_OTHER,
        LDB,
        LDBU,
        LDH,
        LDHU,
        LDW,
        LLW,
        STB,
        STH,
        STW,
        SCW
    } aluop_t;

    // reg_write_data holds the store data for stores
    typedef struct packed {
        logic               inst_valid;
        mem_if_pkg::addr_t  pc;
        aluop_t             aluop;
        mem_if_pkg::addr_t  mem_addr;
        logic               reg_write_en;
        reg_addr_t          reg_write_addr;
        mem_if_pkg::bus32_t reg_write_data;
    } ex_mem_t;

    typedef struct packed {
        logic               inst_valid;
        mem_if_pkg::addr_t  pc;
        logic               reg_write_en;
        reg_addr_t          reg_write_addr;
        mem_if_pkg::bus32_t reg_write_data;
    } mem_wb_t;

    // forwarding toward dispatch
    typedef struct packed {
        logic               reg_write_en;
        reg_addr_t          reg_write_addr;
        mem_if_pkg::bus32_t reg_write_data;
    } fwd_t;

    function automatic logic is_load_op(aluop_t op);
        return op inside {LDB, LDBU, LDH, LDHU, LDW, LLW};
    endfunction

    function automatic logic is_store_op(aluop_t op);
        return op inside {STB, STH, STW, SCW};
    endfunction

endpackage

//--- rtl/mem_if_pkg.sv
package mem_if_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_mask_t;

    // one-cycle strobe, word-aligned address
    typedef struct packed {
        logic       req;
        logic       we;
        addr_t      addr;
        bus32_t     wdata;
        byte_mask_t wstrb;
    } dcache_req_t;

    // data_ok pulses once per request
    typedef struct packed {
        logic   data_ok;
        bus32_t rdata;
    } dcache_rsp_t;

endpackage
